// ==== hw/sp_addr_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_addr_decode (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      cyc_i,
   input  logic                      stb_i,
   input  logic [sp_pkg::ADDR_W-1:0] adr_i,
   output logic                      ram_stb_o,
   output logic                      reg_stb_o,
   output logic                      brg_stb_o,
   input  logic                      ram_ack_i,
   input  logic [sp_pkg::DAT_W-1:0]  ram_dat_i,
   input  logic                      reg_ack_i,
   input  logic [sp_pkg::DAT_W-1:0]  reg_dat_i,
   input  logic                      brg_ack_i,
   input  logic [sp_pkg::DAT_W-1:0]  brg_dat_i,
   output logic                      ack_o,
   output logic [sp_pkg::DAT_W-1:0]  dat_o
);

   sp_pkg::bus_addr_u adr;
   logic              req;
   logic              hit_ram, hit_reg, hit_brg, hit_none;
   logic              none_ack_q;

   assign adr = adr_i;
   assign req = cyc_i & stb_i;

   // low half of the map is all RAM, the high half is split by region byte
   assign hit_ram  = !adr.win.hi;
   assign hit_brg  = adr.win.hi && (adr.rgn.region == sp_pkg::REGION_BRIDGE);
   assign hit_reg  = adr.win.hi && (adr.rgn.region == sp_pkg::REGION_REGS);
   assign hit_none = adr.win.hi && !hit_brg && !hit_reg;

   assign ram_stb_o = req & hit_ram;
   assign reg_stb_o = req & hit_reg;
   assign brg_stb_o = req & hit_brg;

   // unmapped responder, acks once so a stray access cannot hang the host
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= req && hit_none && !none_ack_q;
      end
   end

   assign ack_o = ram_ack_i | reg_ack_i | brg_ack_i | none_ack_q;

   always_comb begin
      if (hit_ram) begin
         dat_o = ram_dat_i;
      end else if (hit_brg) begin
         dat_o = brg_dat_i;
      end else if (hit_reg) begin
         dat_o = reg_dat_i;
      end else begin
         dat_o = '0; // unmapped reads zero
      end
   end

   a_one_target : assert property (@(posedge clk) disable iff (!arst_n_i)
      $onehot0({ram_stb_o, reg_stb_o, brg_stb_o}));

endmodule : sp_addr_decode

`default_nettype wire

// ==== hw/sp_byte_bridge.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_byte_bridge (
   input  logic                          clk,
   input  logic                          arst_n_i,
   input  logic                          stb_i,
   input  logic                          we_i,
   input  logic [sp_pkg::ADDR_W-1:0]     adr_i,
   input  logic [sp_pkg::SEL_W-1:0]      sel_i,
   input  logic [sp_pkg::DAT_W-1:0]      dat_i,
   output logic                          ack_o,
   output logic [sp_pkg::DAT_W-1:0]      dat_o,
   output logic                          ext_cyc_o,
   output logic                          ext_stb_o,
   output logic                          ext_we_o,
   output logic [sp_pkg::EXT_ADDR_W-1:0] ext_adr_o,
   output logic                          ext_sel_o,
   output logic [sp_pkg::EXT_DAT_W-1:0]  ext_dat_o,
   input  logic                          ext_ack_i,
   input  logic [sp_pkg::EXT_DAT_W-1:0]  ext_dat_i
);

   sp_pkg::bus_addr_u        adr;
   logic [1:0]               subaddr;
   logic [1:0]               lane_bit; // sel index of the current lane
   logic                     byte_done;
   logic [sp_pkg::DAT_W-1:0] shift_q;

   assign adr      = adr_i;
   assign lane_bit = ~subaddr;     // lane 0 is the msb byte, sel bit 3

   assign ext_cyc_o = stb_i;
   assign ext_stb_o = stb_i && !ack_o; // idle during the host ack cycle
   assign ext_we_o  = we_i;
   assign ext_adr_o = {adr.rgn.offset[sp_pkg::EXT_ADDR_W-1:2], subaddr};
   assign ext_sel_o = sel_i[lane_bit];
   assign ext_dat_o = dat_i[{lane_bit, 3'b000} +: 8];

   assign byte_done = ext_stb_o && ext_ack_i;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o   <= 1'b0;
         subaddr <= 2'b00;
      end else if (ack_o || !stb_i) begin
         ack_o   <= 1'b0;
         subaddr <= 2'b00;
      end else if (byte_done) begin
         ack_o   <= subaddr == 2'b11; // last lane finishes the host access
         subaddr <= subaddr + 2'd1;
      end
   end

   // bytes arrive lane 0 first and end up in the top byte
   always_ff @(posedge clk) begin
      if (byte_done) begin
         shift_q <= {shift_q[sp_pkg::DAT_W-9:0], ext_dat_i};
      end
   end

   assign dat_o = shift_q;

   a_stb_in_cyc : assert property (@(posedge clk) disable iff (!arst_n_i)
      ext_stb_o |-> ext_cyc_o);

   a_cyc_idle : assert property (@(posedge clk) disable iff (!arst_n_i)
      !stb_i |-> !ext_cyc_o);

endmodule : sp_byte_bridge

`default_nettype wire

// ==== hw/sp_data_fabric.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_data_fabric #(
   parameter int RAM_WORDS = 256
) (
   input  logic                              clk,
   input  logic                              arst_n_i,
   // host port, wishbone classic
   input  logic                              host_cyc_i,
   input  logic                              host_stb_i,
   input  logic                              host_we_i,
   input  logic [sp_pkg::ADDR_W-1:0]         host_adr_i,
   input  logic [sp_pkg::SEL_W-1:0]          host_sel_i,
   input  logic [sp_pkg::DAT_W-1:0]          host_dat_i,
   output logic                              host_ack_o,
   output logic [sp_pkg::DAT_W-1:0]          host_dat_o,
   // external byte bus
   output logic                              ext_cyc_o,
   output logic                              ext_stb_o,
   output logic                              ext_we_o,
   output logic [sp_pkg::EXT_ADDR_W-1:0]     ext_adr_o,
   output logic                              ext_sel_o,
   output logic [sp_pkg::EXT_DAT_W-1:0]      ext_dat_o,
   input  logic                              ext_ack_i,
   input  logic [sp_pkg::EXT_DAT_W-1:0]      ext_dat_i,
   // board i/o
   input  logic [7:0]                        sw_i,
   output logic [7:0]                        led_o
);

   logic                     ram_stb, reg_stb, brg_stb;
   logic                     ram_ack, reg_ack, brg_ack;
   logic [sp_pkg::DAT_W-1:0] ram_dat, reg_dat, brg_dat;

   sp_addr_decode sp_addr_decode_i (
      .clk       (clk),        .arst_n_i  (arst_n_i),
      .cyc_i     (host_cyc_i), .stb_i     (host_stb_i),
      .adr_i     (host_adr_i),
      .ram_stb_o (ram_stb),    .reg_stb_o (reg_stb),    .brg_stb_o (brg_stb),
      .ram_ack_i (ram_ack),    .ram_dat_i (ram_dat),
      .reg_ack_i (reg_ack),    .reg_dat_i (reg_dat),
      .brg_ack_i (brg_ack),    .brg_dat_i (brg_dat),
      .ack_o     (host_ack_o), .dat_o     (host_dat_o)
   );

   sp_scratch_ram #(.RAM_WORDS(RAM_WORDS)) sp_scratch_ram_i (
      .clk   (clk),        .arst_n_i (arst_n_i),
      .stb_i (ram_stb),    .we_i     (host_we_i),
      .adr_i (host_adr_i), .sel_i    (host_sel_i), .dat_i (host_dat_i),
      .ack_o (ram_ack),    .dat_o    (ram_dat)
   );

   sp_regs sp_regs_i (
      .clk   (clk),        .arst_n_i (arst_n_i),
      .stb_i (reg_stb),    .we_i     (host_we_i),
      .adr_i (host_adr_i), .sel_i    (host_sel_i), .dat_i (host_dat_i),
      .sw_i  (sw_i),
      .ack_o (reg_ack),    .dat_o    (reg_dat),    .led_o (led_o)
   );

   sp_byte_bridge sp_byte_bridge_i (
      .clk       (clk),        .arst_n_i  (arst_n_i),
      .stb_i     (brg_stb),    .we_i      (host_we_i),
      .adr_i     (host_adr_i), .sel_i     (host_sel_i), .dat_i (host_dat_i),
      .ack_o     (brg_ack),    .dat_o     (brg_dat),
      .ext_cyc_o (ext_cyc_o),  .ext_stb_o (ext_stb_o),  .ext_we_o (ext_we_o),
      .ext_adr_o (ext_adr_o),  .ext_sel_o (ext_sel_o),  .ext_dat_o (ext_dat_o),
      .ext_ack_i (ext_ack_i),  .ext_dat_i (ext_dat_i)
   );

endmodule : sp_data_fabric

`default_nettype wire

// ==== hw/sp_pkg.sv ====
`default_nettype none

package sp_pkg;

   // host data bus geometry
   localparam int ADDR_W = 32;
   localparam int DAT_W  = 32;
   localparam int SEL_W  = DAT_W / 8;

   // external byte bus
   localparam int EXT_ADDR_W = 24;
   localparam int EXT_DAT_W  = 8;

   // address map, top byte of the host address when the top bit is set
   localparam logic [7:0] REGION_BRIDGE = 8'h80; // external 8-bit bus window
   localparam logic [7:0] REGION_REGS   = 8'hff; // led / switch / id block

   // register block byte offsets
   localparam logic [7:0] REG_LED = 8'h00;
   localparam logic [7:0] REG_SW  = 8'h04;
   localparam logic [7:0] REG_ID  = 8'h08;

   localparam logic [31:0] SP_ID = 32'h5350_0001; // "SP" plus revision

   // region view, used for the register and bridge windows
   typedef struct packed {
      logic [7:0]  region;
      logic [23:0] offset;
   } region_view_t;

   // window view, top bit clear selects scratch RAM
   typedef struct packed {
      logic        hi;
      logic [30:0] offset;
   } window_view_t;

   // one host address word, decoded two ways
   typedef union packed {
      region_view_t rgn;
      window_view_t win;
   } bus_addr_u;

endpackage : sp_pkg

`default_nettype wire

// ==== hw/sp_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_regs (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      stb_i,
   input  logic                      we_i,
   input  logic [sp_pkg::ADDR_W-1:0] adr_i,
   input  logic [sp_pkg::SEL_W-1:0]  sel_i,
   input  logic [sp_pkg::DAT_W-1:0]  dat_i,
   input  logic [7:0]                sw_i,
   output logic                      ack_o,
   output logic [sp_pkg::DAT_W-1:0]  dat_o,
   output logic [7:0]                led_o
);

   sp_pkg::bus_addr_u        adr;
   logic                     take;
   logic                     is_led, is_sw, is_id;
   logic [sp_pkg::DAT_W-1:0] led_q;
   logic [7:0]               sw_meta, sw_sync;
   logic [sp_pkg::DAT_W-1:0] rd_word;

   assign adr  = adr_i;
   assign take = stb_i && !ack_o;

   // full offset compare, aliases above the block read zero
   assign is_led = adr.rgn.offset == {16'h0000, sp_pkg::REG_LED};
   assign is_sw  = adr.rgn.offset == {16'h0000, sp_pkg::REG_SW};
   assign is_id  = adr.rgn.offset == {16'h0000, sp_pkg::REG_ID};

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= take;
      end
   end

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         led_q <= '0;
      end else if (take && we_i && is_led) begin
         for (int l = 0; l < sp_pkg::SEL_W; l++) begin
            if (sel_i[l]) begin
               led_q[8*l +: 8] <= dat_i[8*l +: 8];
            end
         end
      end
   end

   assign led_o = led_q[7:0]; // lane 3 drives the leds

   // switches are asynchronous to clk
   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         sw_meta <= '0;
         sw_sync <= '0;
      end else begin
         sw_meta <= sw_i;
         sw_sync <= sw_meta;
      end
   end

   always_comb begin
      rd_word = '0;
      if (is_led) begin
         rd_word = led_q;
      end else if (is_sw) begin
         rd_word = {24'h000000, sw_sync};
      end else if (is_id) begin
         rd_word = sp_pkg::SP_ID;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         dat_o <= rd_word;
      end
   end

endmodule : sp_regs

`default_nettype wire

// ==== hw/sp_scratch_ram.sv ====
`timescale 1ns/1ns
`default_nettype none

module sp_scratch_ram #(
   parameter int RAM_WORDS = 256
) (
   input  logic                      clk,
   input  logic                      arst_n_i,
   input  logic                      stb_i,
   input  logic                      we_i,
   input  logic [sp_pkg::ADDR_W-1:0] adr_i,
   input  logic [sp_pkg::SEL_W-1:0]  sel_i,
   input  logic [sp_pkg::DAT_W-1:0]  dat_i,
   output logic                      ack_o,
   output logic [sp_pkg::DAT_W-1:0]  dat_o
);

   localparam int IDX_W = $clog2(RAM_WORDS);

   sp_pkg::bus_addr_u        adr;
   logic [IDX_W-1:0]         idx;
   logic                     take;
   logic [sp_pkg::DAT_W-1:0] mem [RAM_WORDS];

   assign adr = adr_i;
   assign idx = adr.win.offset[IDX_W+1:2]; // word offset, wraps at RAM_WORDS

   // accept only on the first cycle of an access
   assign take = stb_i && !ack_o;

   always_ff @(posedge clk or negedge arst_n_i) begin
      if (!arst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= take;
      end
   end

   // byte lane writes, sel bit n covers data bits 8n+7..8n
   always_ff @(posedge clk) begin
      if (take && we_i) begin
         for (int l = 0; l < sp_pkg::SEL_W; l++) begin
            if (sel_i[l]) begin
               mem[idx][8*l +: 8] <= dat_i[8*l +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         dat_o <= mem[idx]; // valid in the ack cycle
      end
   end

   a_ack_pulse : assert property (@(posedge clk) disable iff (!arst_n_i)
      ack_o |=> !ack_o);

endmodule : sp_scratch_ram

`default_nettype wire

// ==== project.f ====
+incdir+tb
hw/sp_pkg.sv
hw/sp_addr_decode.sv
hw/sp_scratch_ram.sv
hw/sp_regs.sv
hw/sp_byte_bridge.sv
hw/sp_data_fabric.sv
tb/tb_sp_fabric.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_sp_fabric -f project.f

out="$(./obj_dir/Vtb_sp_fabric)"
echo "$out"

if echo "$out" | grep -qF -- '*** TEST PASSED ***'; then
   exit 0
fi
exit 1

// ==== tb/sp_fabric_model.svh ====
`ifndef SP_FABRIC_MODEL_SVH
`define SP_FABRIC_MODEL_SVH

// expected contents of the scratch RAM and the led register
logic [31:0] ram_ref [RAM_WORDS];
logic [31:0] led_ref = 32'h0000_0000;

// external byte space as the slave holds it plus the expected copy
logic [7:0] ext_mem [256];
logic [7:0] ext_ref [256];

// one entry per external byte cycle in bus order
logic [sp_pkg::EXT_ADDR_W-1:0] log_adr [$];
logic [7:0]                    log_dat [$];
logic                          log_sel [$];
logic                          log_we  [$];
int                            ext_wait;

// word index of a RAM address wrapping at RAM_WORDS
function automatic logic [IDX_W-1:0] ram_index(input logic [31:0] adr);
   return IDX_W'(adr[30:2] % RAM_WORDS);
endfunction

function automatic logic [31:0] ram_fill(input logic [31:0] adr);
   return (adr * 32'h0101_0101) ^ 32'h6b2d_93e5;
endfunction

function automatic logic [7:0] ext_fill(input logic [7:0] a);
   return (a * 8'd37) ^ 8'h5b;
endfunction

// lane 0 is the most significant byte
function automatic logic [7:0] lane_byte(input logic [31:0] w, input logic [1:0] ln);
   return w[8 * (3 - int'(ln)) +: 8];
endfunction

// sel bit 3 guards lane 0 and sel bit 0 guards lane 3
function automatic logic [31:0] merge_lanes(input logic [31:0] old_w, input logic [31:0] new_w,
                                            input logic [3:0] sel);
   logic [31:0] mask;
   mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
   return (old_w & ~mask) | (new_w & mask);
endfunction

// external byte-bus slave that acks each byte after 0 to 3 idle cycles
initial begin : ext_slave
   logic [7:0] rd;
   ext_ack_i = 1'b0;
   ext_dat_i = 8'h00;
   ext_wait  = 0;
   for (int a = 0; a < 256; a++) begin
      ext_mem[8'(a)] = ext_fill(8'(a));
      ext_ref[8'(a)] = ext_fill(8'(a));
   end
   forever begin
      @(negedge clk); // bus is settled mid-cycle
      if (arst_n_i && ext_cyc_o && ext_stb_o) begin
         if (ext_wait > 0) begin
            ext_wait--;
         end else begin
            log_adr.push_back(ext_adr_o);
            log_dat.push_back(ext_dat_o);
            log_sel.push_back(ext_sel_o);
            log_we.push_back(ext_we_o);
            if (ext_we_o && ext_sel_o) begin
               ext_mem[ext_adr_o[7:0]] = ext_dat_o;
            end
            rd = ext_mem[ext_adr_o[7:0]];
            @(posedge clk);
            #(DRIVE_DLY);
            ext_ack_i = 1'b1;
            ext_dat_i = rd;
            @(posedge clk);
            #(DRIVE_DLY);
            ext_ack_i = 1'b0;
            ext_dat_i = 8'h00;
            ext_wait  = $random(seed) & 3;
         end
      end
   end
end

`endif

// ==== tb/tb_sp_fabric.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sp_fabric;

   localparam int RAM_WORDS   = 256;
   localparam int IDX_W       = $clog2(RAM_WORDS);
   localparam int N_TRANS     = 400;
   localparam int CLK_PERIOD  = 40;
   localparam int DRIVE_DLY   = 2;
   localparam int ACK_LIMIT   = 64;
   // RAM preload plus the random run with every access at the ack limit
   localparam int WATCHDOG_NS = (N_TRANS + RAM_WORDS) * ACK_LIMIT * CLK_PERIOD;

   logic                          clk = 1'b0;
   logic                          arst_n_i;
   logic                          host_cyc_i, host_stb_i, host_we_i, host_ack_o;
   logic [31:0]                   host_adr_i, host_dat_i, host_dat_o;
   logic [3:0]                    host_sel_i;
   logic                          ext_cyc_o, ext_stb_o, ext_we_o, ext_sel_o, ext_ack_i;
   logic [sp_pkg::EXT_ADDR_W-1:0] ext_adr_o;
   logic [7:0]                    ext_dat_o, ext_dat_i, sw_i, led_o;

   integer seed   = 32'h73c5_b365;
   int     errors = 0;
   int     checks = 0;

   `include "sp_fabric_model.svh"

   sp_data_fabric #(.RAM_WORDS(RAM_WORDS)) sp_data_fabric_i (
      .clk        (clk),        .arst_n_i   (arst_n_i),
      .host_cyc_i (host_cyc_i), .host_stb_i (host_stb_i), .host_we_i (host_we_i),
      .host_adr_i (host_adr_i), .host_sel_i (host_sel_i), .host_dat_i (host_dat_i),
      .host_ack_o (host_ack_o), .host_dat_o (host_dat_o),
      .ext_cyc_o  (ext_cyc_o),  .ext_stb_o  (ext_stb_o),  .ext_we_o  (ext_we_o),
      .ext_adr_o  (ext_adr_o),  .ext_sel_o  (ext_sel_o),  .ext_dat_o (ext_dat_o),
      .ext_ack_i  (ext_ack_i),  .ext_dat_i  (ext_dat_i),
      .sw_i       (sw_i),       .led_o      (led_o)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] got);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("[ERROR] %0t ns %s expected %h got %h", $time, name, exp, got);
      end
   endtask

   task automatic drive_idle();
      host_cyc_i = 1'b0;
      host_stb_i = 1'b0;
      host_we_i  = 1'b0;
      host_adr_i = 32'h0;
      host_sel_i = 4'h0;
      host_dat_i = 32'h0;
   endtask

   // one classic cycle entered and left 2 ns after a rising edge
   task automatic host_access(input logic we, input logic [31:0] adr, input logic [3:0] sel,
                              input logic [31:0] wdat, output logic [31:0] rdat,
                              output int edges);
      host_cyc_i = 1'b1;
      host_stb_i = 1'b1;
      host_we_i  = we;
      host_adr_i = adr;
      host_sel_i = sel;
      host_dat_i = wdat;
      edges = 0;
      @(negedge clk);
      while (!host_ack_o && edges < ACK_LIMIT) begin
         @(negedge clk);
         edges++;
      end
      rdat = host_dat_o;
      assert (host_ack_o) else begin
         errors++;
         $display("[ERROR] %0t ns host access never acknowledged at address %h", $time, adr);
      end
      @(posedge clk);
      #(DRIVE_DLY);
      drive_idle();
      @(negedge clk);
      check_value("host_ack_o after ack cycle", 32'h0, 32'(host_ack_o));
      @(posedge clk);
      #(DRIVE_DLY);
   endtask

   task automatic ram_txn();
      logic [31:0] adr, wdat, rdat, rnd;
      int          edges;
      rnd = $random(seed);
      adr = {1'b0, rnd[30:2], 2'b00}; // high bits alias onto the array
      if (rnd[31]) begin
         wdat = $random(seed);
         rnd  = $random(seed);
         host_access(1'b1, adr, rnd[3:0], wdat, rdat, edges);
         check_value("ram write ack latency", 32'd1, 32'(edges));
         ram_ref[ram_index(adr)] = merge_lanes(ram_ref[ram_index(adr)], wdat, rnd[3:0]);
      end
      rnd = $random(seed);
      host_access(1'b0, adr, rnd[3:0], 32'h0, rdat, edges);
      check_value("ram read ack latency", 32'd1, 32'(edges));
      check_value("host_dat_o", ram_ref[ram_index(adr)], rdat);
   endtask

   task automatic bridge_txn();
      logic [31:0] adr, wdat, rdat, rnd, exp;
      logic [3:0]  sel;
      logic [7:0]  a;
      logic [1:0]  ln;
      logic        we;
      int          edges;
      rnd  = $random(seed);
      adr  = {sp_pkg::REGION_BRIDGE, rnd[23:0]};
      we   = rnd[31];
      rnd  = $random(seed);
      sel  = rnd[3:0];
      wdat = $random(seed);
      exp  = 32'h0;
      log_adr.delete();
      log_dat.delete();
      log_sel.delete();
      log_we.delete();
      host_access(we, adr, sel, wdat, rdat, edges);
      check_value("external byte cycles", 32'd4, 32'(log_adr.size()));
      if (log_adr.size() == 4) begin
         for (int k = 0; k < 4; k++) begin
            ln = 2'(k);
            a  = {adr[7:2], ln};
            check_value("ext_adr_o", 32'({adr[23:2], ln}), 32'(log_adr[k]));
            check_value("ext_we_o", 32'(we), 32'(log_we[k]));
            if (we) begin
               check_value("ext_dat_o", 32'(lane_byte(wdat, ln)), 32'(log_dat[k]));
               check_value("ext_sel_o", 32'(sel[3 - int'(ln)]), 32'(log_sel[k]));
               if (sel[3 - int'(ln)]) begin
                  ext_ref[a] = lane_byte(wdat, ln);
               end
               check_value("external byte array", 32'(ext_ref[a]), 32'(ext_mem[a]));
            end
            exp = {exp[23:0], ext_ref[a]};
         end
      end
      if (!we) begin
         check_value("host_dat_o", exp, rdat);
      end
   endtask

   task automatic reg_txn();
      logic [31:0] rnd, wdat, rdat, exp;
      logic [23:0] off;
      logic [7:0]  sw_val;
      int          edges;
      rnd = $random(seed);
      case (rnd[1:0])
         2'd0:    off = {16'h0000, sp_pkg::REG_LED};
         2'd1:    off = {16'h0000, sp_pkg::REG_SW};
         2'd2:    off = {16'h0000, sp_pkg::REG_ID};
         default: off = {rnd[23:4], 4'hc}; // hole inside the block
      endcase
      if (rnd[31]) begin
         wdat = $random(seed);
         host_access(1'b1, {sp_pkg::REGION_REGS, off}, rnd[27:24], wdat, rdat, edges);
         check_value("reg write ack latency", 32'd1, 32'(edges));
         if (off == {16'h0000, sp_pkg::REG_LED}) begin
            led_ref = merge_lanes(led_ref, wdat, rnd[27:24]);
         end
      end
      rnd    = $random(seed);
      sw_val = rnd[7:0];
      sw_i   = sw_val;
      repeat (4) @(posedge clk); // let the synchronizer settle
      #(DRIVE_DLY);
      host_access(1'b0, {sp_pkg::REGION_REGS, off}, 4'hf, 32'h0, rdat, edges);
      check_value("reg read ack latency", 32'd1, 32'(edges));
      case (off)
         {16'h0000, sp_pkg::REG_LED}: exp = led_ref;
         {16'h0000, sp_pkg::REG_SW}:  exp = {24'h000000, sw_val};
         {16'h0000, sp_pkg::REG_ID}:  exp = sp_pkg::SP_ID;
         default:                     exp = 32'h0;
      endcase
      check_value("host_dat_o", exp, rdat);
      check_value("led_o", 32'(led_ref[7:0]), 32'(led_o));
   endtask

   task automatic unmapped_txn();
      logic [31:0] rnd, wdat, rdat;
      logic [7:0]  region;
      int          edges;
      rnd    = $random(seed);
      region = {1'b1, rnd[30:24]};
      if (region == sp_pkg::REGION_BRIDGE || region == sp_pkg::REGION_REGS) begin
         region = 8'hc5;
      end
      wdat = $random(seed);
      host_access(rnd[31], {region, rnd[23:0]}, wdat[3:0], wdat, rdat, edges);
      check_value("unmapped ack latency", 32'd1, 32'(edges));
      check_value("host_dat_o", 32'h0, rdat);
      // the RAM word under the same offset and the leds stay put
      host_access(1'b0, {1'b0, rnd[30:0]}, 4'hf, 32'h0, rdat, edges);
      check_value("host_dat_o", ram_ref[ram_index({1'b0, rnd[30:0]})], rdat);
      check_value("led_o", 32'(led_ref[7:0]), 32'(led_o));
   endtask

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("watchdog expired before the test sequence finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   initial begin : stimulus
      logic [31:0] rnd, rdat;
      int          edges;
      arst_n_i = 1'b0;
      sw_i     = 8'h00;
      drive_idle();
      repeat (16) @(posedge clk);
      #(DRIVE_DLY);
      arst_n_i = 1'b1;
      @(negedge clk);
      check_value("host_ack_o", 32'h0, 32'(host_ack_o));
      check_value("ext_cyc_o", 32'h0, 32'(ext_cyc_o));
      check_value("ext_stb_o", 32'h0, 32'(ext_stb_o));
      check_value("led_o", 32'h0, 32'(led_o));
      @(posedge clk);
      #(DRIVE_DLY);
      for (int w = 0; w < RAM_WORDS; w++) begin
         rnd = 32'(w) << 2;
         host_access(1'b1, rnd, 4'hf, ram_fill(rnd), rdat, edges);
         ram_ref[ram_index(rnd)] = ram_fill(rnd);
      end
      for (int t = 0; t < N_TRANS; t++) begin
         rnd = $random(seed);
         case (rnd[1:0])
            2'd0:    ram_txn();
            2'd1:    bridge_txn();
            2'd2:    reg_txn();
            default: unmapped_txn();
         endcase
      end
      $display("checks: %0d  errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule : tb_sp_fabric

`default_nettype wire
